// ==== bench/cpu_properties.sv ====
`timescale 1ns/1ns

module cpu_properties import cpu_pkg::*; (
  input logic   clka,
  input logic   rst,
  input logic   run,
  input logic   halted,
  input count_t retired
);

  // halt is sticky until the host drops run
  halt_held: assert property (@(posedge clka) disable iff (!rst)
    (halted && run) |=> halted)
    else $error("halted fell while run was still high");

  // one retire per cycle at most, or a clear
  retired_step: assert property (@(posedge clka) disable iff (!rst)
    (retired == $past(retired)) ||
    (retired == count_t'($past(retired) + 1'b1)) ||
    (retired == '0))
    else $error("retired jumped by more than one");

  // counter cleared by the edge that sees run low
  retired_clear: assert property (@(posedge clka) disable iff (!rst)
    $fell(run) |=> (retired == '0))
    else $error("retired not cleared after run fell");

endmodule

// ==== bench/cpu_tb.sv ====
`timescale 1ns/1ns

module cpu_tb import cpu_pkg::*; ();

  localparam addr_t PROG_START = PROGRAM_START_DEFAULT;
  localparam addr_t RES_ADDR   = addr_t'(700);  // well past any program
  localparam addr_t DATA_ADDR  = addr_t'(710);
  localparam int    NUM_TESTS  = 10;
  localparam int    TIMEOUT    = 200;

  typedef enum logic [2:0] {K_NUM, K_PLUS, K_MINUS, K_RAM, K_JMP, K_HOSTWR} kind_t;
  typedef enum logic [1:0] {RULE_A, RULE_SUM, RULE_DIFF} rule_t;

  typedef struct packed {
    kind_t  kind;
    logic   rnd;   // operands drawn from the lfsr
    word_t  a;
    word_t  b;
    rule_t  rule;
    count_t ret;   // instructions on the executed path
  } row_t;

  row_t tests [NUM_TESTS] = '{
    '{K_NUM,    1'b0, 16'h1234, 16'h0000, RULE_A,    16'd3},
    '{K_NUM,    1'b1, 16'h0000, 16'h0000, RULE_A,    16'd3},
    '{K_PLUS,   1'b0, 16'hffff, 16'h0002, RULE_SUM,  16'd4},  // wraps to 1
    '{K_PLUS,   1'b1, 16'h0000, 16'h0000, RULE_SUM,  16'd4},
    '{K_MINUS,  1'b0, 16'h0003, 16'h0005, RULE_DIFF, 16'd4},  // wraps below zero
    '{K_MINUS,  1'b1, 16'h0000, 16'h0000, RULE_DIFF, 16'd4},
    '{K_RAM,    1'b1, 16'h0000, 16'h0000, RULE_A,    16'd3},
    '{K_JMP,    1'b1, 16'h0000, 16'h0000, RULE_A,    16'd4},
    '{K_HOSTWR, 1'b1, 16'h0000, 16'h0000, RULE_A,    16'd3},
    '{K_PLUS,   1'b1, 16'h0000, 16'h0000, RULE_SUM,  16'd4}
  };

  logic        clka;
  logic        rst;
  logic        run;
  logic        host_we;
  addr_t       host_addr;
  word_t       host_wdata;
  word_t       host_rdata;
  logic        halted;
  count_t      retired;
  logic [15:0] lfsr;
  int          errors;
  int          checks;
  logic        test_ok;

  cpu_top #(
    .PROGRAM_START (PROG_START),
    .REG_COUNT     (REG_COUNT_DEFAULT)
  ) dut_i (
    .clka       (clka),
    .rst        (rst),
    .run        (run),
    .host_we    (host_we),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .host_rdata (host_rdata),
    .halted     (halted),
    .retired    (retired)
  );

  bind cpu_top cpu_properties props_i (
    .clka    (clka),
    .rst     (rst),
    .run     (run),
    .halted  (halted),
    .retired (retired)
  );

  always #2 clka = ~clka;

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  task automatic draw_bits(input int n, output word_t v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[14:0], lfsr[0]};
    end
  endtask

  function automatic word_t expected_value(input rule_t rule, input word_t a, input word_t b);
    case (rule)
      RULE_SUM:  return a + b;
      RULE_DIFF: return a - b;
      default:   return a;
    endcase
  endfunction

  task automatic check_word(input string what, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
      test_ok = 1'b0;
    end
  endtask

  task automatic check_count(input string what, input count_t got, input count_t exp);
    checks++;
    if (got !== exp) begin
      $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
      errors++;
      test_ok = 1'b0;
    end
  endtask

  // all host tasks start and end just after a falling edge
  task automatic host_write(input addr_t addr, input word_t data);
    host_we    = 1'b1;
    host_addr  = addr;
    host_wdata = data;
    @(negedge clka);
    host_we    = 1'b0;
  endtask

  task automatic host_read(input addr_t addr, output word_t data);
    host_addr = addr;
    @(negedge clka);
    data = host_rdata;  // registered read, one edge later
  endtask

  task automatic put_instr(inout addr_t at, input opcode_t op, input reg_idx_t r,
                           input word_t arg);
    host_write(at, {op, 3'b000, r});
    host_write(at + addr_t'(1), arg);
    at = at + addr_t'(2);
  endtask

  task automatic load_program(input kind_t kind, input reg_idx_t r, input word_t a,
                              input word_t b);
    addr_t at;
    at = PROG_START;
    if (kind == K_RAM || kind == K_HOSTWR) begin
      host_write(DATA_ADDR, a);
    end
    case (kind)
      K_NUM: put_instr(at, NUM2REG, r, a);
      K_PLUS: begin
        put_instr(at, NUM2REG, r, a);
        put_instr(at, REG_PLUS, r, b);
      end
      K_MINUS: begin
        put_instr(at, NUM2REG, r, a);
        put_instr(at, REG_MINUS, r, b);
      end
      K_JMP: begin
        put_instr(at, NUM2REG, r, a);
        put_instr(at, JMP, '0, word_t'(PROG_START) + 16'd6);  // lands on the store
        put_instr(at, NUM2REG, r, b);                         // skipped
      end
      default: put_instr(at, RAM2REG, r, word_t'(DATA_ADDR));
    endcase
    put_instr(at, REG2RAM, r, word_t'(RES_ADDR));
    put_instr(at, EXIT, '0, '0);
  endtask

  task automatic wait_halted(input logic level, input int limit, output logic ok);
    int n;
    n = 0;
    while (halted !== level && n < limit) begin
      @(negedge clka);
      n++;
    end
    ok = (halted === level);
    if (!ok) begin
      $display("timeout: halted did not go to %0b within %0d cycles", level, limit);
      errors++;
    end
  endtask

  initial begin
    row_t     row;
    kind_t    kind;
    word_t    a;
    word_t    b;
    word_t    tmp;
    word_t    exp;
    word_t    got;
    reg_idx_t r;
    logic     ok;
    int       done;
    clka       = 1'b0;
    rst        = 1'b0;
    run        = 1'b0;
    host_we    = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    lfsr       = 16'd59208;
    errors     = 0;
    checks     = 0;
    done       = 0;
    ok         = 1'b1;
    repeat (8) @(negedge clka);
    rst = 1'b1;
    @(negedge clka);
    for (int i = 0; i < NUM_TESTS && ok; i++) begin
      row     = tests[i];
      kind    = row.kind;
      test_ok = 1'b1;
      a       = row.a;
      b       = row.b;
      if (row.rnd) begin
        draw_bits(16, a);
        draw_bits(16, b);
      end
      if (kind == K_JMP || kind == K_HOSTWR) begin
        b = ~a;  // makes a stray write visible
      end
      draw_bits(5, tmp);
      r   = tmp[4:0];
      exp = expected_value(row.rule, a, b);
      host_write(RES_ADDR, ~exp);  // stale marker
      load_program(kind, r, a, b);
      run = 1'b1;
      if (kind == K_HOSTWR) begin
        @(negedge clka);
        host_write(DATA_ADDR, b);  // core owns memory now
      end
      wait_halted(1'b1, TIMEOUT, ok);
      if (ok) begin
        check_count("retired", retired, row.ret);
        run = 1'b0;
        wait_halted(1'b0, 4, ok);
      end
      if (ok) begin
        host_read(RES_ADDR, got);
        check_word("result word", got, exp);
        if (kind == K_HOSTWR) begin
          host_read(DATA_ADDR, got);
          check_word("data word", got, a);
        end
        done++;
        if (test_ok) begin
          $display("test %0d %s: ok", i, kind.name());
        end else begin
          $display("test %0d %s: mismatch", i, kind.name());
        end
      end
    end
    $display("%0d of %0d tests run, %0d checks, %0d errors", done, NUM_TESTS, checks, errors);
    if (errors == 0 && done == NUM_TESTS) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== project.f ====
rtl/cpu_pkg.sv
rtl/program_memory.sv
rtl/fetch_counter.sv
rtl/execute_unit.sv
rtl/sequencer.sv
rtl/cpu_top.sv
bench/cpu_properties.sv
bench/cpu_tb.sv

// ==== rtl/cpu_pkg.sv ====
package cpu_pkg;

  typedef logic [15:0] word_t;     // memory and register word
  typedef logic [9:0]  addr_t;     // 1024-word space
  typedef logic [4:0]  reg_idx_t;  // low bits of the register field
  typedef logic [15:0] count_t;    // retired instructions

  // upper byte of the first instruction word
  typedef enum logic [7:0] {
    JMP       = 8'd1,
    RAM2REG   = 8'd2,
    REG2RAM   = 8'd3,
    NUM2REG   = 8'd4,
    REG_PLUS  = 8'd5,
    REG_MINUS = 8'd6,
    EXIT      = 8'd17
  } opcode_t;

  typedef enum logic [2:0] {
    FETCH_OP,
    WAIT_OP,
    FETCH_ARG,
    WAIT_ARG,
    EXECUTE,
    LOAD_WAIT,
    STORE,
    HALT
  } seq_state_t;

  localparam addr_t PROGRAM_START_DEFAULT = addr_t'(46);
  localparam int    REG_COUNT_DEFAULT     = 32;

endpackage

// ==== rtl/cpu_top.sv ====
`timescale 1ns/1ns

module cpu_top import cpu_pkg::*; #(
  parameter addr_t PROGRAM_START = PROGRAM_START_DEFAULT,
  parameter int    REG_COUNT     = REG_COUNT_DEFAULT
) (
  input  logic   clka,
  input  logic   rst,
  input  logic   run,
  input  logic   host_we,
  input  addr_t  host_addr,
  input  word_t  host_wdata,
  output word_t  host_rdata,
  output logic   halted,
  output count_t retired
);

  addr_t    mem_addr;
  logic     mem_we;
  word_t    mem_wdata;
  word_t    mem_rdata;

  addr_t    pc;
  logic     pc_clear;
  logic     pc_inc;
  logic     pc_load;
  addr_t    pc_target;
  logic     retire;

  logic     reg_we;
  opcode_t  opcode;
  reg_idx_t reg_idx;
  word_t    operand;
  word_t    reg_rdata;

  program_memory mem_i (
    .clka       (clka),
    .run        (run),
    .host_we    (host_we),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .host_rdata (host_rdata),
    .mem_we     (mem_we),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_rdata  (mem_rdata)
  );

  fetch_counter #(
    .PROGRAM_START (PROGRAM_START)
  ) fetch_i (
    .clka      (clka),
    .rst       (rst),
    .pc_clear  (pc_clear),
    .pc_inc    (pc_inc),
    .pc_load   (pc_load),
    .pc_target (pc_target),
    .pc        (pc),
    .retire    (retire),
    .retired   (retired)
  );

  execute_unit #(
    .REG_COUNT (REG_COUNT)
  ) exec_i (
    .clka      (clka),
    .rst       (rst),
    .reg_we    (reg_we),
    .opcode    (opcode),
    .reg_idx   (reg_idx),
    .operand   (operand),
    .reg_rdata (reg_rdata)
  );

  sequencer seq_i (
    .clka      (clka),
    .rst       (rst),
    .run       (run),
    .pc        (pc),
    .mem_addr  (mem_addr),
    .mem_we    (mem_we),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata),
    .pc_clear  (pc_clear),
    .pc_inc    (pc_inc),
    .pc_load   (pc_load),
    .pc_target (pc_target),
    .retire    (retire),
    .reg_we    (reg_we),
    .opcode    (opcode),
    .reg_idx   (reg_idx),
    .operand   (operand),
    .reg_rdata (reg_rdata),
    .halted    (halted)
  );

endmodule

// ==== rtl/execute_unit.sv ====
`timescale 1ns/1ns

module execute_unit import cpu_pkg::*; #(
  parameter int REG_COUNT = REG_COUNT_DEFAULT
) (
  input  logic     clka,
  input  logic     rst,
  input  logic     reg_we,
  input  opcode_t  opcode,
  input  reg_idx_t reg_idx,
  input  word_t    operand,
  output word_t    reg_rdata
);

  word_t    regs [REG_COUNT];
  reg_idx_t sel;     // register actually addressed
  word_t    result;  // value for write-back

  // smaller banks alias onto the low index bits
  assign sel = reg_idx & reg_idx_t'(REG_COUNT - 1);

  assign reg_rdata = regs[sel];  // read straight through for reg2ram

  always_comb begin
    case (opcode)
      REG_PLUS: begin
        result = reg_rdata + operand;  // wraps mod 2^16
      end
      REG_MINUS: begin
        result = reg_rdata - operand;
      end
      default: begin
        result = operand;  // num2reg and ram2reg
      end
    endcase
  end

  always_ff @(posedge clka) begin
    if (!rst) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (reg_we) begin
      regs[sel] <= result;
    end
  end

endmodule

// ==== rtl/fetch_counter.sv ====
`timescale 1ns/1ns

module fetch_counter import cpu_pkg::*; #(
  parameter addr_t PROGRAM_START = PROGRAM_START_DEFAULT
) (
  input  logic   clka,
  input  logic   rst,
  input  logic   pc_clear,
  input  logic   pc_inc,
  input  logic   pc_load,
  input  addr_t  pc_target,
  output addr_t  pc,
  input  logic   retire,
  output count_t retired
);

  addr_t  pc_q;
  count_t retired_q;

  always_ff @(posedge clka) begin
    if (!rst || pc_clear) begin
      pc_q <= PROGRAM_START;  // restart point for next run
    end else if (pc_load) begin
      pc_q <= pc_target;      // jump wins over increment
    end else if (pc_inc) begin
      pc_q <= pc_q + addr_t'(1);
    end
  end

  always_ff @(posedge clka) begin
    if (!rst || pc_clear) begin
      retired_q <= '0;
    end else if (retire) begin
      retired_q <= retired_q + count_t'(1);  // exit counts too
    end
  end

  assign pc      = pc_q;
  assign retired = retired_q;

endmodule

// ==== rtl/program_memory.sv ====
`timescale 1ns/1ns

module program_memory import cpu_pkg::*; (
  input  logic  clka,
  input  logic  run,
  input  logic  host_we,
  input  addr_t host_addr,
  input  word_t host_wdata,
  output word_t host_rdata,
  input  logic  mem_we,
  input  addr_t mem_addr,
  input  word_t mem_wdata,
  output word_t mem_rdata
);

  localparam int DEPTH = 2 ** $bits(addr_t);

  word_t ram [DEPTH];
  word_t rd_q;      // registered read data

  logic  wr_en;
  word_t wr_data;
  addr_t port_addr;

  // host owns both ports while stopped, core while running
  assign wr_en     = run ? mem_we : host_we;  // host writes dropped while running
  assign wr_data   = run ? mem_wdata : host_wdata;
  assign port_addr = run ? mem_addr : host_addr;

  always_ff @(posedge clka) begin
    if (wr_en) begin
      ram[port_addr] <= wr_data;
    end
    rd_q <= ram[port_addr];  // read-first on same address
  end

  // one read port seen by whoever owns it
  assign host_rdata = rd_q;
  assign mem_rdata  = rd_q;

endmodule

// ==== rtl/sequencer.sv ====
`timescale 1ns/1ns

module sequencer import cpu_pkg::*; (
  input  logic     clka,
  input  logic     rst,
  input  logic     run,
  input  addr_t    pc,
  output addr_t    mem_addr,
  output logic     mem_we,
  output word_t    mem_wdata,
  input  word_t    mem_rdata,
  output logic     pc_clear,
  output logic     pc_inc,
  output logic     pc_load,
  output addr_t    pc_target,
  output logic     retire,
  output logic     reg_we,
  output opcode_t  opcode,
  output reg_idx_t reg_idx,
  output word_t    operand,
  input  word_t    reg_rdata,
  output logic     halted
);

  seq_state_t state;
  seq_state_t state_nxt;

  logic [7:0] op_q;   // raw opcode byte, unknown values act as no-op
  reg_idx_t   reg_q;
  word_t      arg_q;  // address or immediate, later the loaded word

  logic       is_mem_op;
  addr_t      arg_addr;

  assign is_mem_op = (op_q == RAM2REG) || (op_q == REG2RAM);
  assign arg_addr  = arg_q[$bits(addr_t)-1:0];

  always_comb begin
    state_nxt = state;
    case (state)
      FETCH_OP:  state_nxt = WAIT_OP;
      WAIT_OP:   state_nxt = FETCH_ARG;
      FETCH_ARG: state_nxt = WAIT_ARG;
      WAIT_ARG:  state_nxt = EXECUTE;
      EXECUTE: begin
        case (op_q)
          EXIT:    state_nxt = HALT;
          RAM2REG: state_nxt = LOAD_WAIT;
          REG2RAM: state_nxt = STORE;
          default: state_nxt = FETCH_OP;
        endcase
      end
      LOAD_WAIT: state_nxt = STORE;     // store doubles as write-back slot
      STORE:     state_nxt = FETCH_OP;
      HALT:      state_nxt = HALT;      // held until run drops
      default:   state_nxt = FETCH_OP;
    endcase
    if (!run) begin
      state_nxt = FETCH_OP;
    end
  end

  always_ff @(posedge clka) begin
    if (!rst) begin
      state <= FETCH_OP;
    end else begin
      state <= state_nxt;
    end
  end

  // instruction words arrive one cycle after their address
  always_ff @(posedge clka) begin
    if (state == WAIT_OP) begin
      op_q  <= mem_rdata[15:8];
      reg_q <= mem_rdata[$bits(reg_idx_t)-1:0];
    end
    if (state == WAIT_ARG) begin
      arg_q <= mem_rdata;
    end
    if (state == LOAD_WAIT) begin
      arg_q <= mem_rdata;  // loaded word replaces the address
    end
  end

  // pc during fetch, operand address afterwards
  assign mem_addr  = (state == EXECUTE || state == LOAD_WAIT || state == STORE) ?
                     arg_addr : pc;
  assign mem_wdata = reg_rdata;
  assign mem_we    = run && (state == STORE) && (op_q == REG2RAM);

  assign pc_clear  = !run;
  assign pc_inc    = run && (state == FETCH_OP || state == FETCH_ARG);
  assign pc_load   = run && (state == EXECUTE) && (op_q == JMP);
  assign pc_target = arg_addr;

  // memory ops finish in store, the rest in execute
  assign retire = run && (((state == EXECUTE) && !is_mem_op) || (state == STORE));

  assign reg_we = run && (((state == EXECUTE) &&
                           (op_q == NUM2REG || op_q == REG_PLUS || op_q == REG_MINUS)) ||
                          ((state == STORE) && (op_q == RAM2REG)));

  assign opcode  = opcode_t'(op_q);
  assign reg_idx = reg_q;
  assign operand = arg_q;

  assign halted = (state == HALT);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the cpu testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module cpu_tb -f project.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vcpu_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the testbench prints its verdict on a line of its own
if printf '%s\n' "$output" | grep -qx "sim passed"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1
